//--- sim/conv_stim.txt
// Record kinds: 01 weights, 02 input row, 03 expected output row, ff end of data
// 02 and 03 records: kind, tag, last, then elements from flat index 0 upward
// Input row elements: pixel 0 ch0, pixel 0 ch1, pixel 1 ch0, ... (16 values)
// Output row elements: col 0 oc0, col 0 oc1, col 1 oc0, ... (12 values)
// Weights: output channel, input channel, kernel row, kernel column, Q4 format
01
// oc0 ic0, every tap 1.0
10 10 10 10 10 10 10 10 10
// oc0 ic1, unused
00 00 00 00 00 00 00 00 00
// oc1 ic0, half taps at (0,0) and (1,1) exercise the per-product shift
08 00 00 00 08 00 00 00 00
// oc1 ic1, taps 1.0 to 9.0 so that row and column order both matter
10 20 30 40 50 60 70 80 90
// Image of four rows, two output rows
02 1 0 11 20 12 21 13 22 14 23 15 24 16 25 17 26 18 27
02 2 0 08 45 09 46 0A 47 0B 48 0C 49 0D 4A 0E 4B 0F 4C
02 3 0 33 0A 34 0B 35 0C 36 0D 37 0E 38 0F 39 10 3A 11
03 3 0 ED FA F6 29 FF 56 08 85 11 B2 1A E1
02 4 1 02 90 03 91 04 92 05 93 06 94 07 95 08 96 09 97
03 4 1 C0 05 C9 32 D2 61 DB 8E E4 BD ED EA
// Image of two rows, shorter than the kernel, no output
02 5 0 66 77 67 78 68 79 69 7A 6A 7B 6B 7C 6C 7D 6D 7E
02 6 1 44 55 45 56 46 57 47 58 48 59 49 5A 4A 5B 4B 5C
// Image of three rows starting from an empty window
02 7 0 21 13 22 14 23 15 24 16 25 17 26 18 27 19 28 1A
02 8 0 0C 30 0D 31 0E 32 0F 33 10 34 11 35 12 36 13 37
02 9 1 7F C0 80 C1 81 C2 82 C3 83 C4 84 C5 85 C6 86 C7
03 9 1 0D 8B 16 BA 1F E7 28 16 31 43 3A 72
ff

//--- filelist.f
+incdir+sim
rtl/conv_pkg.sv
rtl/line_window_buffer.sv
rtl/conv_mac.sv
rtl/conv_sequencer.sv
rtl/output_row_buffer.sv
rtl/conv_row_layer.sv
sim/conv_row_layer_tb.sv

//--- sim/conv_tb_checks.svh
`ifndef CONV_TB_CHECKS_SVH
`define CONV_TB_CHECKS_SVH

// Compare helpers for the DUT result types, included inside the testbench module

// One output element
task automatic compare_value(input value_t got, input value_t exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                            $time, what, got, exp));
    end
endtask

// Row tag
task automatic compare_tag(input tag_t got, input tag_t exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                            $time, what, got, exp));
    end
endtask

// Single flag such as last, valid or accept
task automatic compare_last(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                            $time, what, got, exp));
    end
endtask

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

`endif

//--- sim/conv_row_layer_tb.sv
`timescale 1ns/10ps

module conv_row_layer_tb import conv_pkg::*; ();

    localparam int KERNEL_SIZE = KERNEL_SIZE_DEF;
    localparam int ROW_WIDTH = ROW_WIDTH_DEF;
    localparam int IN_CHANNELS = IN_CHANNELS_DEF;
    localparam int OUT_CHANNELS = OUT_CHANNELS_DEF;
    localparam int OUT_WIDTH = ROW_WIDTH - KERNEL_SIZE + 1;
    localparam int VB = $bits(value_t);
    localparam int WB = $bits(weight_t);
    localparam int WT_N = OUT_CHANNELS * IN_CHANNELS * KERNEL_SIZE * KERNEL_SIZE;
    localparam int ROW_N = ROW_WIDTH * IN_CHANNELS;
    localparam int OUT_N = OUT_WIDTH * OUT_CHANNELS;
    // Transfer edge to offered output row
    localparam int ROW_CYCLES = OUT_N + 2;
    localparam int RESET_CYCLES = 5;
    localparam int STIM_DEPTH = 1024;

    logic               clock;
    logic               reset;
    logic [WT_N*WB-1:0] weights;
    logic [ROW_N*VB-1:0] in_row;
    logic               in_row_valid;
    logic               in_row_last;
    tag_t               in_row_tag;
    logic               in_row_accept;
    logic [OUT_N*VB-1:0] out_row;
    logic               out_row_valid;
    logic               out_row_last;
    tag_t               out_row_tag;
    logic               out_row_accept;

    logic [7:0]          stim_mem [STIM_DEPTH];
    logic [ROW_N*VB-1:0] in_rows [$];
    tag_t                in_tags [$];
    logic                in_lasts [$];
    logic [OUT_N*VB-1:0] exp_rows [$];
    tag_t                exp_tags [$];
    logic                exp_lasts [$];
    int                  timeout_limit;
    int                  cycle_count;
    logic [31:0]         lfsr_state;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "conv_tb_checks.svh"

    // Record kinds 01 weights, 02 input row, 03 expected row, ff end
    task automatic load_stimulus();
        int ptr;
        logic [7:0] kind;
        logic [ROW_N*VB-1:0] row;
        logic [OUT_N*VB-1:0] exp_row;
        ptr = 0;
        $readmemh("sim/conv_stim.txt", stim_mem);
        kind = stim_mem[0];
        while (kind !== 8'hff) begin
            case (kind)
                8'h01: begin
                    for (int i = 0; i < WT_N; i++) begin
                        weights[i*WB +: WB] = stim_mem[ptr + 1 + i];
                    end
                    ptr = ptr + 1 + WT_N;
                end
                8'h02: begin
                    for (int i = 0; i < ROW_N; i++) begin
                        row[i*VB +: VB] = stim_mem[ptr + 3 + i];
                    end
                    in_rows.push_back(row);
                    in_tags.push_back(tag_t'(stim_mem[ptr + 1]));
                    in_lasts.push_back(stim_mem[ptr + 2][0]);
                    ptr = ptr + 3 + ROW_N;
                end
                8'h03: begin
                    for (int i = 0; i < OUT_N; i++) begin
                        exp_row[i*VB +: VB] = stim_mem[ptr + 3 + i];
                    end
                    exp_rows.push_back(exp_row);
                    exp_tags.push_back(tag_t'(stim_mem[ptr + 1]));
                    exp_lasts.push_back(stim_mem[ptr + 2][0]);
                    ptr = ptr + 3 + OUT_N;
                end
                default: abort_run("Stimulus file has an unknown record or no end marker");
            endcase
            kind = stim_mem[ptr];
        end
    endtask

    // Element order is pixel first, then output channel
    task automatic check_offered_row(input logic [OUT_N*VB-1:0] exp_row, input tag_t exp_tag,
                                     input logic exp_last);
        for (int i = 0; i < OUT_N; i++) begin
            compare_value(out_row[i*VB +: VB], exp_row[i*VB +: VB],
                          $sformatf("tag %0h col %0d oc %0d", exp_tag, i / OUT_CHANNELS,
                                    i % OUT_CHANNELS));
        end
        compare_tag(out_row_tag, exp_tag, "out_row_tag_o");
        compare_last(out_row_last, exp_last, "out_row_last_o");
    endtask

    conv_row_layer #(
        .KERNEL_SIZE(KERNEL_SIZE),
        .ROW_WIDTH(ROW_WIDTH),
        .IN_CHANNELS(IN_CHANNELS),
        .OUT_CHANNELS(OUT_CHANNELS),
        .WEIGHT_Q_SHIFT(WEIGHT_Q_SHIFT_DEF)
    ) conv_row_layer_i (
        .clock_i(clock), .reset_i(reset), .weights_i(weights), .in_row_i(in_row),
        .in_row_valid_i(in_row_valid), .in_row_last_i(in_row_last), .in_row_tag_i(in_row_tag),
        .in_row_accept_o(in_row_accept), .out_row_o(out_row), .out_row_valid_o(out_row_valid),
        .out_row_last_o(out_row_last), .out_row_tag_o(out_row_tag),
        .out_row_accept_i(out_row_accept)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (timeout_limit > 0 && cycle_count > timeout_limit) begin
                abort_run($sformatf("Timeout after %0d cycles, not all output rows arrived",
                                    timeout_limit));
            end
        end
    end

    // Random consumer back-pressure, one LFSR bit per cycle
    initial begin
        lfsr_state = 32'h9cd9_a513;
        forever begin
            @(posedge clock);
            lfsr_state = lfsr_step(lfsr_state);
            out_row_accept <= lfsr_state[0];
        end
    end

    // Output monitor, sampled on the falling edge
    initial begin
        logic prev_valid;
        logic prev_accept;
        prev_valid = 1'b0;
        prev_accept = 1'b0;
        wait (reset === 1'b0);
        forever begin
            @(negedge clock);
            if (in_row_accept && out_row_valid) begin
                abort_run("An input row was accepted while an output row was pending");
            end
            if (prev_valid && !prev_accept && !out_row_valid) begin
                abort_run("The output row was withdrawn before the consumer accepted it");
            end
            if (out_row_valid) begin
                if (exp_rows.size() == 0) begin
                    abort_run("The DUT offered an output row that was not expected");
                end else begin
                    check_offered_row(exp_rows[0], exp_tags[0], exp_lasts[0]);
                    if (out_row_accept) begin
                        void'(exp_rows.pop_front());
                        void'(exp_tags.pop_front());
                        void'(exp_lasts.pop_front());
                    end
                end
            end
            prev_valid = out_row_valid;
            prev_accept = out_row_accept;
        end
    end

    initial begin
        logic accepted;
        reset = 1'b1;
        weights = '0;
        in_row = '0;
        in_row_valid = 1'b0;
        in_row_last = 1'b0;
        in_row_tag = '0;
        out_row_accept = 1'b0;
        timeout_limit = 0;
        load_stimulus();
        timeout_limit = RESET_CYCLES + in_rows.size() * ROW_CYCLES * 4 + 200;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        compare_last(in_row_accept, 1'b0, "in_row_accept_o after reset");
        compare_last(out_row_valid, 1'b0, "out_row_valid_o after reset");
        compare_last(out_row_last, 1'b0, "out_row_last_o after reset");
        @(posedge clock);
        // Each row is held until its transfer edge
        for (int i = 0; i < in_rows.size(); i++) begin
            in_row <= in_rows[i];
            in_row_tag <= in_tags[i];
            in_row_last <= in_lasts[i];
            in_row_valid <= 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clock);
                accepted = in_row_accept;
            end
            @(posedge clock);
        end
        in_row_valid <= 1'b0;
        while (exp_rows.size() != 0) begin
            @(posedge clock);
        end
        // Quiet period so that a surplus output row is caught by the monitor
        repeat (ROW_CYCLES + 4) @(posedge clock);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- rtl/conv_row_layer.sv
`timescale 1ns/10ps

module conv_row_layer import conv_pkg::*; #(
    parameter int KERNEL_SIZE = KERNEL_SIZE_DEF,
    parameter int ROW_WIDTH = ROW_WIDTH_DEF,
    parameter int IN_CHANNELS = IN_CHANNELS_DEF,
    parameter int OUT_CHANNELS = OUT_CHANNELS_DEF,
    parameter int WEIGHT_Q_SHIFT = WEIGHT_Q_SHIFT_DEF,
    localparam int OUT_WIDTH = ROW_WIDTH - KERNEL_SIZE + 1,
    localparam int WT_BITS = OUT_CHANNELS * IN_CHANNELS * KERNEL_SIZE * KERNEL_SIZE
                             * $bits(weight_t),
    localparam int ROW_BITS = ROW_WIDTH * IN_CHANNELS * $bits(value_t),
    localparam int OUT_BITS = OUT_WIDTH * OUT_CHANNELS * $bits(value_t)
) (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic [WT_BITS-1:0]  weights_i,
    input  logic [ROW_BITS-1:0] in_row_i,
    input  logic                in_row_valid_i,
    input  logic                in_row_last_i,
    input  tag_t                in_row_tag_i,
    output logic                in_row_accept_o,
    output logic [OUT_BITS-1:0] out_row_o,
    output logic                out_row_valid_o,
    output logic                out_row_last_o,
    output tag_t                out_row_tag_o,
    input  logic                out_row_accept_i
);

    localparam int COL_W = (OUT_WIDTH > 1) ? $clog2(OUT_WIDTH) : 1;
    localparam int OC_W = (OUT_CHANNELS > 1) ? $clog2(OUT_CHANNELS) : 1;
    localparam int WIN_BITS = KERNEL_SIZE * KERNEL_SIZE * IN_CHANNELS * $bits(value_t);

    logic                shift_row;
    logic [COL_W-1:0]    col_sel;
    logic [WIN_BITS-1:0] window;
    logic [OC_W-1:0]     oc_sel;
    logic                issue;
    value_t              result;
    logic                result_valid;
    logic [OC_W-1:0]     result_oc;
    logic [COL_W-1:0]    result_col;
    logic                row_done;
    logic                row_last;
    tag_t                row_tag;
    logic                busy;

    line_window_buffer #(
        .KERNEL_SIZE(KERNEL_SIZE), .ROW_WIDTH(ROW_WIDTH), .IN_CHANNELS(IN_CHANNELS)
    ) line_window_buffer_i (
        .clock_i(clock_i), .reset_i(reset_i), .row_i(in_row_i), .shift_row_i(shift_row),
        .col_sel_i(col_sel), .window_o(window)
    );

    conv_mac #(
        .KERNEL_SIZE(KERNEL_SIZE), .ROW_WIDTH(ROW_WIDTH), .IN_CHANNELS(IN_CHANNELS),
        .OUT_CHANNELS(OUT_CHANNELS), .WEIGHT_Q_SHIFT(WEIGHT_Q_SHIFT)
    ) conv_mac_i (
        .clock_i(clock_i), .reset_i(reset_i), .weights_i(weights_i), .window_i(window),
        .issue_i(issue), .oc_sel_i(oc_sel), .col_i(col_sel), .result_o(result),
        .result_valid_o(result_valid), .result_oc_o(result_oc), .result_col_o(result_col)
    );

    conv_sequencer #(
        .KERNEL_SIZE(KERNEL_SIZE), .ROW_WIDTH(ROW_WIDTH), .OUT_CHANNELS(OUT_CHANNELS)
    ) conv_sequencer_i (
        .clock_i(clock_i), .reset_i(reset_i), .in_row_valid_i(in_row_valid_i),
        .in_row_last_i(in_row_last_i), .in_row_tag_i(in_row_tag_i),
        .result_valid_i(result_valid), .out_busy_i(busy), .in_row_accept_o(in_row_accept_o),
        .shift_row_o(shift_row), .col_sel_o(col_sel), .oc_sel_o(oc_sel), .issue_o(issue),
        .row_done_o(row_done), .row_last_o(row_last), .row_tag_o(row_tag)
    );

    output_row_buffer #(
        .ROW_WIDTH(ROW_WIDTH), .KERNEL_SIZE(KERNEL_SIZE), .OUT_CHANNELS(OUT_CHANNELS)
    ) output_row_buffer_i (
        .clock_i(clock_i), .reset_i(reset_i), .result_i(result),
        .result_valid_i(result_valid), .result_oc_i(result_oc), .result_col_i(result_col),
        .row_done_i(row_done), .row_last_i(row_last), .row_tag_i(row_tag),
        .out_row_accept_i(out_row_accept_i), .out_row_o(out_row_o),
        .out_row_valid_o(out_row_valid_o), .out_row_last_o(out_row_last_o),
        .out_row_tag_o(out_row_tag_o), .busy_o(busy)
    );

endmodule

//--- rtl/output_row_buffer.sv
`timescale 1ns/10ps

module output_row_buffer import conv_pkg::*; #(
    parameter int ROW_WIDTH = ROW_WIDTH_DEF,
    parameter int KERNEL_SIZE = KERNEL_SIZE_DEF,
    parameter int OUT_CHANNELS = OUT_CHANNELS_DEF,
    localparam int OUT_WIDTH = ROW_WIDTH - KERNEL_SIZE + 1,
    localparam int COL_W = (OUT_WIDTH > 1) ? $clog2(OUT_WIDTH) : 1,
    localparam int OC_W = (OUT_CHANNELS > 1) ? $clog2(OUT_CHANNELS) : 1,
    localparam int OUT_BITS = OUT_WIDTH * OUT_CHANNELS * $bits(value_t)
) (
    input  logic                clock_i,
    input  logic                reset_i,
    input  value_t              result_i,
    input  logic                result_valid_i,
    input  logic [OC_W-1:0]     result_oc_i,
    input  logic [COL_W-1:0]    result_col_i,
    input  logic                row_done_i,
    input  logic                row_last_i,
    input  tag_t                row_tag_i,
    input  logic                out_row_accept_i,
    output logic [OUT_BITS-1:0] out_row_o,
    output logic                out_row_valid_o,
    output logic                out_row_last_o,
    output tag_t                out_row_tag_o,
    output logic                busy_o
);

    localparam int VB = $bits(value_t);

    logic [OUT_BITS-1:0] row_q;
    logic                valid_q;
    logic                last_q;
    tag_t                tag_q;

    assign out_row_o = row_q;
    assign out_row_valid_o = valid_q;
    assign out_row_last_o = last_q;
    assign out_row_tag_o = tag_q;
    assign busy_o = valid_q;

    // Element slot is pixel first, then output channel
    always_ff @(posedge clock_i) begin
        if (result_valid_i) begin
            row_q[(int'(result_col_i) * OUT_CHANNELS + int'(result_oc_i))*VB +: VB] <= result_i;
        end
        if (row_done_i) begin
            tag_q <= row_tag_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else if (row_done_i) begin
            valid_q <= 1'b1;
            last_q <= row_last_i;
        end else if (valid_q && out_row_accept_i) begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end
    end

    // No new results may reach the row while it waits for the consumer
    a_hold_stable: assert property (
        @(posedge clock_i) disable iff (reset_i)
        out_row_valid_o && !out_row_accept_i |=>
            out_row_valid_o && $stable(out_row_o) && $stable(out_row_tag_o)
            && $stable(out_row_last_o)
    );

endmodule

//--- rtl/conv_sequencer.sv
`timescale 1ns/10ps

module conv_sequencer import conv_pkg::*; #(
    parameter int KERNEL_SIZE = KERNEL_SIZE_DEF,
    parameter int ROW_WIDTH = ROW_WIDTH_DEF,
    parameter int OUT_CHANNELS = OUT_CHANNELS_DEF,
    localparam int OUT_WIDTH = ROW_WIDTH - KERNEL_SIZE + 1,
    localparam int COL_W = (OUT_WIDTH > 1) ? $clog2(OUT_WIDTH) : 1,
    localparam int OC_W = (OUT_CHANNELS > 1) ? $clog2(OUT_CHANNELS) : 1
) (
    input  logic             clock_i,
    input  logic             reset_i,
    input  logic             in_row_valid_i,
    input  logic             in_row_last_i,
    input  tag_t             in_row_tag_i,
    input  logic             result_valid_i,
    input  logic             out_busy_i,
    output logic             in_row_accept_o,
    output logic             shift_row_o,
    output logic [COL_W-1:0] col_sel_o,
    output logic [OC_W-1:0]  oc_sel_o,
    output logic             issue_o,
    output logic             row_done_o,
    output logic             row_last_o,
    output tag_t             row_tag_o
);

    localparam int CNT_W = $clog2(KERNEL_SIZE + 1);

    typedef enum logic [1:0] {
        WAIT_ROW,
        SWEEP,
        DRAIN,
        HOLD
    } state_t;

    state_t state_q;
    state_t state_d;

    // Number of rows held in the window up to KERNEL_SIZE
    logic [CNT_W-1:0] row_count_q;
    logic [COL_W-1:0] col_q;
    logic [OC_W-1:0]  oc_q;
    logic             row_done_q;
    logic             row_last_q;
    tag_t             row_tag_q;

    logic accept;
    logic window_full;
    logic sweep_end;

    assign accept = (state_q == WAIT_ROW) && in_row_valid_i && !out_busy_i;
    // This row completes a window once KERNEL_SIZE-1 rows are already held
    assign window_full = row_count_q >= CNT_W'(KERNEL_SIZE - 1);
    assign sweep_end = (col_q == COL_W'(OUT_WIDTH - 1)) && (oc_q == OC_W'(OUT_CHANNELS - 1));

    assign in_row_accept_o = accept;
    assign shift_row_o = accept;
    assign issue_o = (state_q == SWEEP);
    assign col_sel_o = col_q;
    assign oc_sel_o = oc_q;
    assign row_done_o = row_done_q;
    assign row_last_o = row_last_q;
    assign row_tag_o = row_tag_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT_ROW: begin
                if (accept && window_full) begin
                    state_d = SWEEP;
                end
            end
            SWEEP: begin
                if (sweep_end) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // Final result lands here one cycle after the last issue
                if (result_valid_i) begin
                    state_d = HOLD;
                end
            end
            HOLD: begin
                // Busy lags row_done by one cycle since output valid rises the edge after it
                if (!row_done_q && !out_busy_i) begin
                    state_d = WAIT_ROW;
                end
            end
            default: state_d = WAIT_ROW;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= WAIT_ROW;
            row_count_q <= '0;
            col_q <= '0;
            oc_q <= '0;
            row_done_q <= 1'b0;
            row_last_q <= 1'b0;
        end else begin
            state_q <= state_d;
            row_done_q <= (state_q == DRAIN) && result_valid_i;
            if (accept) begin
                row_last_q <= in_row_last_i;
                col_q <= '0;
                oc_q <= '0;
                // Image end empties the window for the next image
                if (in_row_last_i) begin
                    row_count_q <= '0;
                end else if (row_count_q != CNT_W'(KERNEL_SIZE)) begin
                    row_count_q <= row_count_q + 1'b1;
                end
            end
            // Channels in the inner loop and columns in the outer loop
            if (state_q == SWEEP) begin
                if (oc_q == OC_W'(OUT_CHANNELS - 1)) begin
                    oc_q <= '0;
                    col_q <= col_q + 1'b1;
                end else begin
                    oc_q <= oc_q + 1'b1;
                end
            end
        end
        if (accept) begin
            row_tag_q <= in_row_tag_i;
        end
    end

    // A pending output row keeps the sequencer out of WAIT_ROW
    a_idle_output_free: assert property (
        @(posedge clock_i) disable iff (reset_i)
        (state_q == WAIT_ROW) |-> !out_busy_i
    );

endmodule

//--- rtl/conv_mac.sv
`timescale 1ns/10ps

module conv_mac import conv_pkg::*; #(
    parameter int KERNEL_SIZE = KERNEL_SIZE_DEF,
    parameter int ROW_WIDTH = ROW_WIDTH_DEF,
    parameter int IN_CHANNELS = IN_CHANNELS_DEF,
    parameter int OUT_CHANNELS = OUT_CHANNELS_DEF,
    parameter int WEIGHT_Q_SHIFT = WEIGHT_Q_SHIFT_DEF,
    localparam int OUT_WIDTH = ROW_WIDTH - KERNEL_SIZE + 1,
    localparam int COL_W = (OUT_WIDTH > 1) ? $clog2(OUT_WIDTH) : 1,
    localparam int OC_W = (OUT_CHANNELS > 1) ? $clog2(OUT_CHANNELS) : 1,
    localparam int TAPS = IN_CHANNELS * KERNEL_SIZE * KERNEL_SIZE,
    localparam int WT_BITS = OUT_CHANNELS * TAPS * $bits(weight_t),
    localparam int WIN_BITS = TAPS * $bits(value_t)
) (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic [WT_BITS-1:0]  weights_i,
    input  logic [WIN_BITS-1:0] window_i,
    input  logic                issue_i,
    input  logic [OC_W-1:0]     oc_sel_i,
    input  logic [COL_W-1:0]    col_i,
    output value_t              result_o,
    output logic                result_valid_o,
    output logic [OC_W-1:0]     result_oc_o,
    output logic [COL_W-1:0]    result_col_o
);

    localparam int VB = $bits(value_t);
    localparam int WB = $bits(weight_t);

    acc_t acc;

    // Dot product against the weight set of the selected output channel
    always_comb begin
        int w_idx;
        int p_idx;
        weight_t w;
        value_t p;
        acc = '0;
        for (int ic = 0; ic < IN_CHANNELS; ic++) begin
            for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
                for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                    w_idx = int'(oc_sel_i) * TAPS + (ic * KERNEL_SIZE + kr) * KERNEL_SIZE + kc;
                    p_idx = (kr * KERNEL_SIZE + kc) * IN_CHANNELS + ic;
                    w = weights_i[w_idx*WB +: WB];
                    p = window_i[p_idx*VB +: VB];
                    // Each product is scaled before it is summed
                    acc = acc + ((acc_t'(w) * acc_t'(p)) >> WEIGHT_Q_SHIFT);
                end
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= issue_i;
        end
        result_o <= value_t'(acc);
        result_oc_o <= oc_sel_i;
        result_col_o <= col_i;
    end

    // Issued positions must exist in the window and in the weight set
    a_issue_in_range: assert property (
        @(posedge clock_i) disable iff (reset_i)
        issue_i |-> (int'(col_i) < OUT_WIDTH) && (int'(oc_sel_i) < OUT_CHANNELS)
    );

endmodule

//--- rtl/line_window_buffer.sv
`timescale 1ns/10ps

module line_window_buffer import conv_pkg::*; #(
    parameter int KERNEL_SIZE = KERNEL_SIZE_DEF,
    parameter int ROW_WIDTH = ROW_WIDTH_DEF,
    parameter int IN_CHANNELS = IN_CHANNELS_DEF,
    localparam int OUT_WIDTH = ROW_WIDTH - KERNEL_SIZE + 1,
    localparam int COL_W = (OUT_WIDTH > 1) ? $clog2(OUT_WIDTH) : 1,
    localparam int ROW_BITS = ROW_WIDTH * IN_CHANNELS * $bits(value_t),
    localparam int WIN_BITS = KERNEL_SIZE * KERNEL_SIZE * IN_CHANNELS * $bits(value_t)
) (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic [ROW_BITS-1:0] row_i,
    input  logic                shift_row_i,
    input  logic [COL_W-1:0]    col_sel_i,
    output logic [WIN_BITS-1:0] window_o
);

    localparam int VB = $bits(value_t);

    // Entry 0 is the oldest row and maps to kernel row 0
    logic [ROW_BITS-1:0] rows_q [KERNEL_SIZE];

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                rows_q[r] <= '0;
            end
        end else if (shift_row_i) begin
            // Oldest row drops out at the top
            for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
                rows_q[r] <= rows_q[r + 1];
            end
            rows_q[KERNEL_SIZE - 1] <= row_i;
        end
    end

    // Column mux, window left edge at col_sel_i
    // Window order is kernel row, kernel column, then channel
    always_comb begin
        int src_idx;
        int dst_idx;
        window_o = '0;
        for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
            for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                for (int ch = 0; ch < IN_CHANNELS; ch++) begin
                    src_idx = (int'(col_sel_i) + kc) * IN_CHANNELS + ch;
                    dst_idx = (kr * KERNEL_SIZE + kc) * IN_CHANNELS + ch;
                    window_o[dst_idx*VB +: VB] = rows_q[kr][src_idx*VB +: VB];
                end
            end
        end
    end

endmodule

//--- rtl/conv_pkg.sv
package conv_pkg;

    // Default layer geometry, overridden through the top level parameters
    parameter int KERNEL_SIZE_DEF = 3;
    parameter int ROW_WIDTH_DEF = 8;
    parameter int IN_CHANNELS_DEF = 2;
    parameter int OUT_CHANNELS_DEF = 2;

    // Fixed-point scaling applied to every product
    parameter int WEIGHT_Q_SHIFT_DEF = 4;

    // Unsigned pixel value, input and output
    typedef logic [7:0] value_t;

    // Unsigned kernel weight
    typedef logic [7:0] weight_t;

    // Row tag carried from input row to output row
    typedef logic [3:0] tag_t;

    // Holds the sum of all shifted products before truncation to value_t
    typedef logic [19:0] acc_t;

endpackage
